// ==== src/flash_pkg.sv ====
package flash_pkg;

	// bus word and flash byte
	typedef logic [31:0] word_t;
	typedef logic [7:0] flash_byte_t;

	// byte address on the internal bus
	typedef logic [31:0] bus_adr_t;

	// flash reader FSM
	typedef enum logic {
		IDLE,  // waiting for cyc & stb
		FETCH  // pacing the four byte reads
	} reader_state_t;

	// boot copier FSM
	typedef enum logic [1:0] {
		COPY_READ,   // flash word read
		COPY_WRITE,  // RAM word write
		COPY_DONE    // boot finished, bus handed to host
	} copy_state_t;

	// address bit set = boot RAM region, clear = flash region
	localparam int RAM_SEL_BIT = 28;

endpackage

// ==== src/flash_reader.sv ====
`timescale 1ns/10ps

module flash_reader #(
	parameter int FLASH_ADR_WIDTH = 16,
	parameter logic [3:0] ACCESS_CYCLES = 4'd3  // access time in cycles, minus one
) (
	input logic sys_clk,
	input logic sys_rst,

	input flash_pkg::bus_adr_t wb_adr_i,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	output flash_pkg::word_t wb_dat_o,
	output logic wb_ack_o,

	output logic [FLASH_ADR_WIDTH-1:0] flash_adr_o,
	input flash_pkg::flash_byte_t flash_d_i
);

	flash_pkg::reader_state_t state_q;
	flash_pkg::reader_state_t state_d;

	logic [FLASH_ADR_WIDTH-3:0] adr_msb_q;  // word address, held for the whole fetch
	logic [1:0] adr_lsb_q;                  // byte within word, 0 first
	logic [23:0] dat_hi_q;                  // bytes 0..2 of the word
	logic [3:0] wait_cnt_q;
	logic cnt_done;
	logic load;                             // current byte is valid on flash_d_i

	assign flash_adr_o = {adr_msb_q, adr_lsb_q};
	assign cnt_done = (wait_cnt_q == ACCESS_CYCLES);

	// byte 3 goes straight from the pins, it is valid in the ack cycle
	assign wb_dat_o = {dat_hi_q, flash_d_i};

	// address and data capture
	always_ff @(posedge sys_clk) begin
		// word address only latched when a new request starts
		if ((state_q == flash_pkg::IDLE) && wb_cyc_i && wb_stb_i)
			adr_msb_q <= wb_adr_i[FLASH_ADR_WIDTH-1:2];
		if (load) begin
			case (adr_lsb_q)
				2'b00: dat_hi_q[23:16] <= flash_d_i;  // msb lane
				2'b01: dat_hi_q[15:8] <= flash_d_i;
				2'b10: dat_hi_q[7:0] <= flash_d_i;
				default: ;  // lane 3 read live at ack
			endcase
		end
	end

	// low address bits, wrap to 0 after byte 3
	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			adr_lsb_q <= 2'd0;
		else if (load)
			adr_lsb_q <= adr_lsb_q + 2'd1;
	end

	// access time counter, runs only while fetching
	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			wait_cnt_q <= 4'd0;
		else if ((state_q == flash_pkg::FETCH) && !cnt_done)
			wait_cnt_q <= wait_cnt_q + 4'd1;
		else
			wait_cnt_q <= 4'd0;  // restart for next byte
	end

	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			state_q <= flash_pkg::IDLE;
		else
			state_q <= state_d;
	end

	always_comb begin
		state_d = state_q;
		load = 1'b0;
		wb_ack_o = 1'b0;
		case (state_q)
			flash_pkg::IDLE: begin
				if (wb_cyc_i && wb_stb_i)
					state_d = flash_pkg::FETCH;
			end
			flash_pkg::FETCH: begin
				if (cnt_done) begin
					load = 1'b1;
					// last byte, word complete
					if (adr_lsb_q == 2'b11) begin
						wb_ack_o = 1'b1;
						state_d = flash_pkg::IDLE;
					end
				end
			end
			default: state_d = flash_pkg::IDLE;
		endcase
	end

endmodule

// ==== src/boot_ram.sv ====
`timescale 1ns/10ps

module boot_ram #(
	parameter int RAM_ADR_WIDTH = 6  // word address bits
) (
	input logic sys_clk,
	input logic sys_rst,

	input flash_pkg::bus_adr_t wb_adr_i,
	input flash_pkg::word_t wb_dat_i,
	input logic wb_we_i,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	output flash_pkg::word_t wb_dat_o,
	output logic wb_ack_o
);

	flash_pkg::word_t mem [0:(2**RAM_ADR_WIDTH)-1];

	logic [RAM_ADR_WIDTH-1:0] word_idx;
	logic req;  // new access, not the cycle of its own ack

	assign word_idx = wb_adr_i[RAM_ADR_WIDTH+1:2];  // byte address -> word index
	assign req = wb_cyc_i & wb_stb_i & ~wb_ack_o;

	// array with registered read
	always_ff @(posedge sys_clk) begin
		if (req && wb_we_i)
			mem[word_idx] <= wb_dat_i;
		wb_dat_o <= mem[word_idx];
	end

	// one-shot ack, low for a cycle after each ack
	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			wb_ack_o <= 1'b0;
		else
			wb_ack_o <= req;
	end

endmodule

// ==== src/boot_copier.sv ====
`timescale 1ns/10ps

module boot_copier #(
	parameter int BOOT_WORDS = 16,
	parameter int RAM_ADR_WIDTH = 6
) (
	input logic sys_clk,
	input logic sys_rst,

	output flash_pkg::bus_adr_t cp_adr_o,
	output flash_pkg::word_t cp_dat_o,
	output logic cp_we_o,
	output logic cp_cyc_o,
	output logic cp_stb_o,
	input flash_pkg::word_t cp_dat_i,
	input logic cp_ack_i,

	output logic boot_done_o
);

	flash_pkg::copy_state_t state_q;

	logic [RAM_ADR_WIDTH-1:0] idx_q;  // current boot word
	flash_pkg::word_t dat_q;          // word in transit flash -> RAM
	logic act_q;                      // bus request active
	logic last_word;
	flash_pkg::bus_adr_t word_adr;    // byte address of word idx_q
	flash_pkg::bus_adr_t ram_base;

	assign last_word = (idx_q == RAM_ADR_WIDTH'(BOOT_WORDS - 1));
	assign word_adr = flash_pkg::bus_adr_t'(idx_q) << 2;
	assign ram_base = flash_pkg::bus_adr_t'(1) << flash_pkg::RAM_SEL_BIT;

	// same word index in both regions, RAM one has the select bit
	assign cp_adr_o = (state_q == flash_pkg::COPY_WRITE) ? (word_adr | ram_base) : word_adr;
	assign cp_dat_o = dat_q;
	assign cp_we_o = (state_q == flash_pkg::COPY_WRITE);
	assign cp_cyc_o = act_q;
	assign cp_stb_o = act_q;  // single beat, stb follows cyc
	assign boot_done_o = (state_q == flash_pkg::COPY_DONE);

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state_q <= flash_pkg::COPY_READ;
			idx_q <= '0;
			act_q <= 1'b0;  // bus request starts after reset
		end else begin
			case (state_q)
				flash_pkg::COPY_READ: begin
					act_q <= 1'b1;
					if (cp_ack_i)
						state_q <= flash_pkg::COPY_WRITE;
				end
				flash_pkg::COPY_WRITE: begin
					if (cp_ack_i) begin
						if (last_word) begin
							state_q <= flash_pkg::COPY_DONE;
							act_q <= 1'b0;  // release bus for good
						end else begin
							idx_q <= idx_q + 1'b1;
							state_q <= flash_pkg::COPY_READ;
						end
					end
				end
				default: act_q <= 1'b0;  // done, stays until reset
			endcase
		end
	end

	// latch flash word on read ack
	always_ff @(posedge sys_clk) begin
		if ((state_q == flash_pkg::COPY_READ) && cp_ack_i)
			dat_q <= cp_dat_i;
	end

endmodule

// ==== src/bus_mux.sv ====
`timescale 1ns/10ps

module bus_mux (
	input logic boot_done_i,  // 0: copier owns bus, 1: host

	// copier master
	input flash_pkg::bus_adr_t cp_adr_i,
	input flash_pkg::word_t cp_dat_i,
	input logic cp_we_i,
	input logic cp_cyc_i,
	input logic cp_stb_i,
	output flash_pkg::word_t cp_dat_o,
	output logic cp_ack_o,

	// host master
	input flash_pkg::bus_adr_t host_adr_i,
	input flash_pkg::word_t host_dat_i,
	input logic host_we_i,
	input logic host_cyc_i,
	input logic host_stb_i,
	output flash_pkg::word_t host_dat_o,
	output logic host_ack_o,

	// flash reader slave, read only
	output flash_pkg::bus_adr_t fl_adr_o,
	output logic fl_cyc_o,
	output logic fl_stb_o,
	input flash_pkg::word_t fl_dat_i,
	input logic fl_ack_i,

	// boot RAM slave
	output flash_pkg::bus_adr_t ram_adr_o,
	output flash_pkg::word_t ram_dat_o,
	output logic ram_we_o,
	output logic ram_cyc_o,
	output logic ram_stb_o,
	input flash_pkg::word_t ram_dat_i,
	input logic ram_ack_i
);

	flash_pkg::bus_adr_t m_adr;
	logic m_cyc;
	logic m_stb;
	logic sel_ram;  // region decode of owning master
	flash_pkg::word_t s_dat;
	logic s_ack;

	// owning master
	assign m_adr = boot_done_i ? host_adr_i : cp_adr_i;
	assign m_cyc = boot_done_i ? host_cyc_i : cp_cyc_i;
	assign m_stb = boot_done_i ? host_stb_i : cp_stb_i;
	assign sel_ram = m_adr[flash_pkg::RAM_SEL_BIT];

	assign fl_adr_o = m_adr;
	assign fl_cyc_o = m_cyc & ~sel_ram;
	assign fl_stb_o = m_stb & ~sel_ram;

	assign ram_adr_o = m_adr;
	assign ram_dat_o = boot_done_i ? host_dat_i : cp_dat_i;
	assign ram_we_o = boot_done_i ? host_we_i : cp_we_i;  // flash side has no we
	assign ram_cyc_o = m_cyc & sel_ram;
	assign ram_stb_o = m_stb & sel_ram;

	// return path from selected slave
	assign s_dat = sel_ram ? ram_dat_i : fl_dat_i;
	assign s_ack = sel_ram ? ram_ack_i : fl_ack_i;

	assign cp_dat_o = s_dat;
	assign host_dat_o = s_dat;
	assign cp_ack_o = s_ack & ~boot_done_i;
	assign host_ack_o = s_ack & boot_done_i;  // host held off during boot

endmodule

// ==== src/flash_subsys.sv ====
`timescale 1ns/10ps

module flash_subsys #(
	parameter int FLASH_ADR_WIDTH = 16,
	parameter logic [3:0] ACCESS_CYCLES = 4'd3,
	parameter int BOOT_WORDS = 16,
	parameter int RAM_ADR_WIDTH = 6
) (
	input logic sys_clk,
	input logic sys_rst,

	// host port, wishbone classic
	input flash_pkg::bus_adr_t host_adr_i,
	input flash_pkg::word_t host_dat_i,
	input logic host_we_i,
	input logic host_cyc_i,
	input logic host_stb_i,
	output flash_pkg::word_t host_dat_o,
	output logic host_ack_o,

	// external NOR flash
	output logic [FLASH_ADR_WIDTH-1:0] flash_adr_o,
	input flash_pkg::flash_byte_t flash_d_i,

	output logic boot_done_o
);

	// copier master bus
	flash_pkg::bus_adr_t cp_adr;
	flash_pkg::word_t cp_dat_w;
	flash_pkg::word_t cp_dat_r;
	logic cp_we, cp_cyc, cp_stb, cp_ack;

	// flash reader slave bus
	flash_pkg::bus_adr_t fl_adr;
	flash_pkg::word_t fl_dat;
	logic fl_cyc, fl_stb, fl_ack;

	// boot RAM slave bus
	flash_pkg::bus_adr_t ram_adr;
	flash_pkg::word_t ram_dat_w;
	flash_pkg::word_t ram_dat_r;
	logic ram_we, ram_cyc, ram_stb, ram_ack;

	logic boot_done;

	assign boot_done_o = boot_done;

	boot_copier #(
		.BOOT_WORDS(BOOT_WORDS),
		.RAM_ADR_WIDTH(RAM_ADR_WIDTH)
	) u_copier (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.cp_adr_o(cp_adr), .cp_dat_o(cp_dat_w), .cp_we_o(cp_we),
		.cp_cyc_o(cp_cyc), .cp_stb_o(cp_stb),
		.cp_dat_i(cp_dat_r), .cp_ack_i(cp_ack),
		.boot_done_o(boot_done)
	);

	bus_mux u_mux (
		.boot_done_i(boot_done),
		.cp_adr_i(cp_adr), .cp_dat_i(cp_dat_w), .cp_we_i(cp_we),
		.cp_cyc_i(cp_cyc), .cp_stb_i(cp_stb),
		.cp_dat_o(cp_dat_r), .cp_ack_o(cp_ack),
		.host_adr_i(host_adr_i), .host_dat_i(host_dat_i), .host_we_i(host_we_i),
		.host_cyc_i(host_cyc_i), .host_stb_i(host_stb_i),
		.host_dat_o(host_dat_o), .host_ack_o(host_ack_o),
		.fl_adr_o(fl_adr), .fl_cyc_o(fl_cyc), .fl_stb_o(fl_stb),
		.fl_dat_i(fl_dat), .fl_ack_i(fl_ack),
		.ram_adr_o(ram_adr), .ram_dat_o(ram_dat_w), .ram_we_o(ram_we),
		.ram_cyc_o(ram_cyc), .ram_stb_o(ram_stb),
		.ram_dat_i(ram_dat_r), .ram_ack_i(ram_ack)
	);

	flash_reader #(
		.FLASH_ADR_WIDTH(FLASH_ADR_WIDTH),
		.ACCESS_CYCLES(ACCESS_CYCLES)
	) u_reader (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.wb_adr_i(fl_adr), .wb_cyc_i(fl_cyc), .wb_stb_i(fl_stb),
		.wb_dat_o(fl_dat), .wb_ack_o(fl_ack),
		.flash_adr_o(flash_adr_o), .flash_d_i(flash_d_i)
	);

	boot_ram #(
		.RAM_ADR_WIDTH(RAM_ADR_WIDTH)
	) u_ram (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.wb_adr_i(ram_adr), .wb_dat_i(ram_dat_w), .wb_we_i(ram_we),
		.wb_cyc_i(ram_cyc), .wb_stb_i(ram_stb),
		.wb_dat_o(ram_dat_r), .wb_ack_o(ram_ack)
	);

endmodule

// ==== tb/flash_model.sv ====
`timescale 1ns/10ps

// asynchronous NOR flash, read only
// no strobes, data follows the address pins
module flash_model #(
	parameter int ADR_WIDTH = 16  // byte address bits, at least 16
) (
	input logic [ADR_WIDTH-1:0] adr_i,
	output flash_pkg::flash_byte_t d_o
);

	logic [15:0] a;  // low 16 bits feed the content rule

	assign a = adr_i[15:0];

	// content is a fixed function of the address
	// so any word can be predicted without a memory image
	assign d_o = a[7:0] ^ a[15:8] ^ 8'h5a;

endmodule

// ==== tb/tb_flash_subsys.sv ====
`timescale 1ns/10ps

module tb_flash_subsys;

	localparam int FLASH_ADR_WIDTH = 16;
	localparam logic [3:0] ACCESS_CYCLES = 4'd3;
	localparam int BOOT_WORDS = 16;
	localparam int RAM_ADR_WIDTH = 6;

	localparam int CLK_PERIOD = 4;  // ns
	localparam int RESET_CYCLES = 5;
	localparam int FLASH_LAT = 4 * (int'(ACCESS_CYCLES) + 1);  // stb seen -> ack
	localparam int OP_CYCLES = FLASH_LAT + 4;                  // bound per access
	localparam int N_RAND = 8;                                 // random flash reads
	localparam int N_OPS = BOOT_WORDS + N_RAND + 4;
	localparam int RAM_WR_WORD = BOOT_WORDS + 5;  // past the copied words
	localparam int EARLY_WORD = 7;                // boot word read during boot
	localparam int WATCHDOG_CYCLES =
		(N_OPS + 1) * OP_CYCLES + BOOT_WORDS * OP_CYCLES + RESET_CYCLES + 200;
	localparam logic [31:0] RAM_BASE = 32'h1 << flash_pkg::RAM_SEL_BIT;

	logic sys_clk;
	logic sys_rst;
	flash_pkg::bus_adr_t host_adr;
	flash_pkg::word_t host_wdat;
	logic host_we;
	logic host_cyc;
	logic host_stb;
	flash_pkg::word_t host_rdat;
	logic host_ack;
	logic [FLASH_ADR_WIDTH-1:0] flash_adr;
	flash_pkg::flash_byte_t flash_d;
	logic boot_done;

	// host operation table
	logic tbl_we [N_OPS];
	flash_pkg::bus_adr_t tbl_adr [N_OPS];
	flash_pkg::word_t tbl_wdat [N_OPS];
	flash_pkg::word_t tbl_exp [N_OPS];
	logic tbl_lat [N_OPS];  // check flash ack latency
	int tbl_len;
	logic [31:0] rng;

	flash_subsys #(
		.FLASH_ADR_WIDTH(FLASH_ADR_WIDTH),
		.ACCESS_CYCLES(ACCESS_CYCLES),
		.BOOT_WORDS(BOOT_WORDS),
		.RAM_ADR_WIDTH(RAM_ADR_WIDTH)
	) DUT (
		.sys_clk(sys_clk), .sys_rst(sys_rst),
		.host_adr_i(host_adr), .host_dat_i(host_wdat), .host_we_i(host_we),
		.host_cyc_i(host_cyc), .host_stb_i(host_stb),
		.host_dat_o(host_rdat), .host_ack_o(host_ack),
		.flash_adr_o(flash_adr), .flash_d_i(flash_d),
		.boot_done_o(boot_done)
	);

	flash_model #(.ADR_WIDTH(FLASH_ADR_WIDTH)) u_flash (.adr_i(flash_adr), .d_o(flash_d));

	initial begin
		sys_clk = 1'b0;
		forever #(CLK_PERIOD / 2) sys_clk = ~sys_clk;
	end

	// bounds boot plus every table access
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: no progress after %0d cycles, boot or a host access hung",
			WATCHDOG_CYCLES);
		$display("STATUS: FAIL");
		$fatal(1, "watchdog expired");
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// flash content rule for the byte at address a
	function automatic flash_pkg::flash_byte_t rule_byte(input logic [15:0] a);
		return a[7:0] ^ a[15:8] ^ 8'h5a;
	endfunction

	// word at a byte address with the lowest byte address in the msb lane
	function automatic flash_pkg::word_t rule_word(input flash_pkg::bus_adr_t adr);
		flash_pkg::word_t w;
		w = '0;
		for (int i = 0; i < 4; i++)
			w = {w[23:0], rule_byte(adr[15:0] + 16'(i))};
		return w;
	endfunction

	function automatic void add_op(input logic we, input flash_pkg::bus_adr_t adr,
		input flash_pkg::word_t wdat, input flash_pkg::word_t exp, input logic lat);
		tbl_we[tbl_len] = we;
		tbl_adr[tbl_len] = adr;
		tbl_wdat[tbl_len] = wdat;
		tbl_exp[tbl_len] = exp;
		tbl_lat[tbl_len] = lat;
		tbl_len++;
	endfunction

	task automatic build_table();
		flash_pkg::bus_adr_t adr;
		tbl_len = 0;
		for (int w = 0; w < BOOT_WORDS; w++) begin  // copied boot words
			adr = RAM_BASE | (flash_pkg::bus_adr_t'(w) << 2);
			add_op(1'b0, adr, '0, rule_word(flash_pkg::bus_adr_t'(w) << 2), 1'b0);
		end
		for (int n = 0; n < N_RAND; n++) begin  // random flash words
			rng = xorshift32(rng);
			adr = flash_pkg::bus_adr_t'(rng[FLASH_ADR_WIDTH-1:2]) << 2;
			add_op(1'b0, adr, '0, rule_word(adr), 1'b1);
		end
		rng = xorshift32(rng);
		adr = RAM_BASE | (flash_pkg::bus_adr_t'(RAM_WR_WORD) << 2);
		add_op(1'b1, adr, rng, '0, 1'b0);   // ram write
		add_op(1'b0, adr, '0, rng, 1'b0);   // and read back
		rng = xorshift32(rng);
		adr = flash_pkg::bus_adr_t'(rng[FLASH_ADR_WIDTH-1:2]) << 2;
		add_op(1'b1, adr, ~rule_word(adr), '0, 1'b1);  // flash write the reader ignores
		add_op(1'b0, adr, '0, rule_word(adr), 1'b1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR t=%0t %s got %h expected %h", $time, name, got, exp);
			$display("STATUS: FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	// one classic cycle with cycles counted from the first cycle stb is high
	task automatic host_access(input logic we, input flash_pkg::bus_adr_t adr,
		input flash_pkg::word_t wdat, output flash_pkg::word_t rdat, output int cycles);
		@(posedge sys_clk);
		host_we <= we;
		host_adr <= adr;
		host_wdat <= wdat;
		host_cyc <= 1'b1;
		host_stb <= 1'b1;
		cycles = 0;
		@(negedge sys_clk);  // outputs settled mid cycle
		while (!host_ack) begin
			cycles++;
			@(negedge sys_clk);
		end
		check_value("boot_done_o at host ack", 32'(boot_done), 32'd1);
		rdat = host_rdat;
		@(posedge sys_clk);  // drop stb in the cycle after ack
		host_cyc <= 1'b0;
		host_stb <= 1'b0;
		host_we <= 1'b0;
	endtask

	initial begin
		flash_pkg::word_t rdat;
		int cycles;
		sys_rst = 1'b1;
		host_adr = '0;
		host_wdat = '0;
		host_we = 1'b0;
		host_cyc = 1'b0;
		host_stb = 1'b0;
		rng = 32'h5ad8;
		build_table();

		for (int i = 0; i < RESET_CYCLES; i++) begin
			@(posedge sys_clk);
			if (i == RESET_CYCLES - 1)
				sys_rst <= 1'b0;
			@(negedge sys_clk);
			check_value("host_ack_o", 32'(host_ack), 32'd0);
			check_value("boot_done_o", 32'(boot_done), 32'd0);
		end
		@(negedge sys_clk);  // second cycle out of reset
		check_value("host_ack_o", 32'(host_ack), 32'd0);
		check_value("boot_done_o", 32'(boot_done), 32'd0);

		// ram read issued while the copier owns the bus is held off until boot done
		host_access(1'b0, RAM_BASE | (flash_pkg::bus_adr_t'(EARLY_WORD) << 2), '0,
			rdat, cycles);
		check_value("host_dat_o early read", rdat,
			rule_word(flash_pkg::bus_adr_t'(EARLY_WORD) << 2));

		for (int i = 0; i < tbl_len; i++) begin
			host_access(tbl_we[i], tbl_adr[i], tbl_wdat[i], rdat, cycles);
			if (!tbl_we[i])
				check_value($sformatf("host_dat_o op %0d", i), rdat, tbl_exp[i]);
			if (tbl_lat[i])
				check_value($sformatf("flash ack latency op %0d", i), 32'(cycles),
					32'(FLASH_LAT));
		end

		$display("STATUS: PASS");
		$finish;
	end

endmodule

// ==== src.f ====
src/flash_pkg.sv
src/flash_reader.sv
src/boot_ram.sv
src/boot_copier.sv
src/bus_mux.sv
src/flash_subsys.sv
tb/flash_model.sv
tb/tb_flash_subsys.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
	--top-module tb_flash_subsys \
	-f src.f \
	-o sim_tb

# the testbench stops with a non-zero status on failure, the log decides
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "STATUS: PASS" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi
